// File: compile.f
jag_io_pkg.sv
keypad_matrix.sv
joypad_scanner.sv
analog_adc.sv
ebus_mux.sv
jag_io_top.sv
jag_io_chk.sv
tb_jag_io.sv

// File: Makefile
TOP := tb_jag_io
SRCS := $(shell cat compile.f)

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /all tests passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: tb_jag_io.sv
`timescale 1ns/1ns

module tb_jag_io import jag_io_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int N_XFERS = 3 + 7 + 24 * 3 + 3 + 6 * 32;  // Bus transfers over all tests
	localparam int WATCHDOG_CYCLES = N_XFERS * 10 + RESET_CYCLES;

	logic                 sys_clk, xresetl;
	logic                 wb_cyc, wb_stb, wb_we, wb_ack;
	logic [WB_ADR_W-1:0]  wb_adr;
	logic [WB_DAT_W-1:0]  wb_wdat, wb_rdat;
	logic [JOY_BTN_W-1:0] joy0, joy1;   // Port 1 and port 2 presses
	logic [ANALOG_W-1:0]  ana [4];
	logic                 ntsc;

	logic [31:0] lfsr = 32'h4809;
	logic [15:0] rd_data;               // Last word read back
	logic [7:0]  adc_mdl;               // Expected ADC register
	string       cur_test;
	int          test_errs, total_errs, checks, tests_run, tests_bad;
	// Button index by column and row position
	// Empty positions hold -1
	int btn_map [4][6] = '{'{8, 4, 3, 2, 1, 0}, '{-1, 5, 19, 15, 12, 9},
		'{-1, 6, 18, 16, 13, 10}, '{-1, 7, 20, 17, 14, 11}};

	jag_io_top dut0 (
		.sys_clk      (sys_clk),
		.xresetl      (xresetl),
		.wb_cyc_i     (wb_cyc),
		.wb_stb_i     (wb_stb),
		.wb_we_i      (wb_we),
		.wb_adr_i     (wb_adr),
		.wb_dat_i     (wb_wdat),
		.wb_dat_o     (wb_rdat),
		.wb_ack_o     (wb_ack),
		.joystick_0_i (joy0),
		.joystick_1_i (joy1),
		.analog_0_i   (ana[0]),
		.analog_1_i   (ana[1]),
		.analog_2_i   (ana[2]),
		.analog_3_i   (ana[3]),
		.ntsc_i       (ntsc)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;  // 50 MHz
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("Run timed out after %0d cycles, bus traffic never finished", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	// Galois LFSR, right shifting
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};  // One step per bit
		end
	endtask

	// Rows pulled low by pressed buttons in selected columns
	function automatic logic [5:0] expect_rows(input logic [3:0] col_n,
		input logic [JOY_BTN_W-1:0] btn);
		logic [5:0] rows;
		rows = '1;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 6; r++) begin
				if (!col_n[c] && btn_map[c][r] >= 0 && btn[btn_map[c][r]])
					rows[r] = 1'b0;
			end
		end
		return rows;
	endfunction

	task automatic expect_pads(input logic [7:0] lat, output logic [15:0] joy,
		output logic [15:0] btn);
		logic [3:0] p2_col;
		logic [5:0] r1, r2;
		for (int k = 0; k < 4; k++) begin
			p2_col[k] = lat[7 - k];  // Port 2 reversed
		end
		r1 = expect_rows(lat[3:0], joy0);
		r2 = expect_rows(p2_col, joy1);
		joy = {r2[5:2], r1[5:2], lat[7:1], 1'b1};
		btn = {8'hFF, 1'b0, 1'b1, 1'b1, ntsc, r2[1:0], r1[1:0]};
	endtask

	function automatic logic [7:0] expect_adc(input int m, input int c, input logic [7:0] prev);
		int other;
		int d;
		other = (c == 0) ? 1 : (c == 1) ? 0 : (c == 2) ? 3 : 2;  // Pairs 0/1 and 2/3
		if (m == 1) return ana[c];
		if (m == 3 && c == 3) return prev;                       // Ref 3 on itself holds
		if (m == 3) other = 3;
		d = int'(ana[c]) - int'(ana[other]);
		return (d < 0) ? 8'd0 : d[7:0];                          // Clamp at zero
	endfunction

	task automatic check_val(input string what, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			$display("Error %s %s: expected %h actual %h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	// Leaves stb up so a following call runs back-to-back
	task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
		input logic [WB_DAT_W-1:0] dat);
		int n;
		n = 0;
		@(posedge sys_clk);
		wb_cyc  <= 1'b1;
		wb_stb  <= 1'b1;
		wb_we   <= we;
		wb_adr  <= adr;
		wb_wdat <= dat;
		do begin
			@(negedge sys_clk);  // Ack and data settled here
			n++;
		end while (!wb_ack && n < 8);
		if (!wb_ack) begin
			$display("DUT gave no ack within 8 cycles at address %0d", adr);
			test_errs++;
		end else begin
			check_val("ack latency", 16'd1, 16'(n - 1));
		end
		rd_data = wb_rdat;
	endtask

	task automatic wb_idle();
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
		wb_access(1'b1, adr, dat);
		wb_idle();
	endtask

	task automatic read_check(input logic [WB_ADR_W-1:0] adr, input logic [15:0] exp,
		input string what);
		wb_access(1'b0, adr, 16'h0000);
		wb_idle();
		check_val(what, exp, rd_data);
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: FAIL with %0d errors", cur_test, test_errs);
			tests_bad++;
		end
		test_errs = 0;
	endtask

	initial begin
		logic [31:0] rv;
		logic [7:0]  lat;
		logic [15:0] exp_joy, exp_btn;
		xresetl = 1'b0;
		wb_cyc  = 1'b1;                        // Request pending through reset
		wb_stb  = 1'b1;
		wb_we   = 1'b0;
		wb_adr  = '0;
		wb_wdat = '0;
		joy0    = '0;
		joy1    = '0;
		ntsc    = 1'b1;
		for (int k = 0; k < 4; k++) ana[k] = 8'h5A;  // Nonzero so a stray ADC load shows
		repeat (RESET_CYCLES - 1) @(posedge sys_clk);
		wb_cyc  <= 1'b0;                       // Bus idle before release
		wb_stb  <= 1'b0;
		@(posedge sys_clk);
		xresetl <= 1'b1;

		cur_test = "reset";
		expect_pads(8'hFF, exp_joy, exp_btn);  // Latch idles all ones
		read_check(REG_JOY, exp_joy, "joy word");
		read_check(REG_BTN, exp_btn, "b bus");
		read_check(REG_ADC, 16'hFF00, "adc result");
		end_test();

		cur_test = "handshake";
		wb_access(1'b1, REG_JOY, 16'h00A5);    // Write then read, stb held
		wb_access(1'b0, REG_JOY, 16'h0000);
		expect_pads(8'hA5, exp_joy, exp_btn);
		check_val("joy after back-to-back", exp_joy, rd_data);
		wb_access(1'b0, 2'd3, 16'h0000);
		check_val("unmapped read", 16'hFFFF, rd_data);
		wb_idle();
		wb_write(2'd3, 16'h0005);              // Both ignored
		wb_write(REG_BTN, 16'h0005);
		read_check(REG_JOY, exp_joy, "joy after ignored writes");
		read_check(REG_ADC, 16'hFF00, "adc after ignored writes");
		end_test();

		cur_test = "keypad";
		repeat (24) begin
			rand_bits(8, rv);
			lat = rv[7:0];
			@(posedge sys_clk);
			rand_bits(JOY_BTN_W, rv);
			joy0 <= rv[JOY_BTN_W-1:0];
			rand_bits(JOY_BTN_W, rv);
			joy1 <= rv[JOY_BTN_W-1:0];
			wb_write(REG_JOY, {8'h00, lat});
			expect_pads(lat, exp_joy, exp_btn);
			read_check(REG_JOY, exp_joy, $sformatf("joy word latch %h", lat));
			read_check(REG_BTN, exp_btn, $sformatf("b bus latch %h", lat));
		end
		end_test();

		cur_test = "jumpers";
		for (int i = 0; i < 3; i++) begin
			@(posedge sys_clk);
			ntsc <= (i == 1);                  // 0, 1, 0
			expect_pads(lat, exp_joy, exp_btn);
			read_check(REG_BTN, {8'hFF, 3'b011, i == 1, exp_btn[3:0]}, "b bus jumpers");
		end
		end_test();

		cur_test = "adc";
		adc_mdl = 8'h00;
		repeat (6) begin
			@(posedge sys_clk);
			for (int k = 0; k < 4; k++) begin
				rand_bits(ANALOG_W, rv);
				ana[k] <= rv[ANALOG_W-1:0];
			end
			for (int m = 0; m < 4; m++) begin
				for (int c = 0; c < 4; c++) begin
					rand_bits(4, rv);              // Unused nibble gets noise
					wb_write(REG_ADC, {8'h00, rv[3:0], 2'(m), 2'(c)});
					adc_mdl = expect_adc(m, c, adc_mdl);
					read_check(REG_ADC, {8'hFF, adc_mdl}, $sformatf("mode %0d chan %0d", m, c));
				end
			end
		end
		end_test();

		$display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
			tests_run, tests_bad, checks, total_errs);
		if (total_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: jag_io_chk.sv
`timescale 1ns/1ns

module jag_io_chk import jag_io_pkg::*; (
	input logic                sys_clk,
	input logic                xresetl,
	input logic                wb_cyc_i,
	input logic                wb_stb_i,
	input logic                wb_we_i,
	input logic [WB_ADR_W-1:0] wb_adr_i,
	input logic [WB_DAT_W-1:0] wb_rdat_i,  // Slave read data
	input logic                wb_ack_i
);

	logic new_req;  // Fresh access, slave not acking yet
	logic rd_req;

	assign new_req = wb_cyc_i & wb_stb_i & ~wb_ack_i;
	assign rd_req = new_req & ~wb_we_i;

	// Fixed latency, no wait states
	ack_after_req: assert property (@(posedge sys_clk) disable iff (!xresetl)
		new_req |=> wb_ack_i) else $error("ack missing one cycle after request");

	// Single cycle pulse
	ack_single: assert property (@(posedge sys_clk) disable iff (!xresetl)
		wb_ack_i |=> !wb_ack_i) else $error("ack high two cycles running");

	ack_in_reset: assert property (@(posedge sys_clk)
		!xresetl |=> !wb_ack_i) else $error("ack high during reset");

	// Address 3 has no driver
	unmapped_read: assert property (@(posedge sys_clk) disable iff (!xresetl)
		(rd_req && wb_adr_i == 2'd3) |=> wb_rdat_i == EBUS_PULLUP)
		else $error("unmapped read not pulled up");

	// Byte-wide sources, upper lanes float
	upper_byte: assert property (@(posedge sys_clk) disable iff (!xresetl)
		(rd_req && (wb_adr_i == REG_BTN || wb_adr_i == REG_ADC)) |=> wb_rdat_i[15:8] == 8'hFF)
		else $error("upper byte of BTN or ADC read not all ones");

endmodule

bind jag_io_top jag_io_chk chk0 (
	.sys_clk   (sys_clk),
	.xresetl   (xresetl),
	.wb_cyc_i  (wb_cyc_i),
	.wb_stb_i  (wb_stb_i),
	.wb_we_i   (wb_we_i),
	.wb_adr_i  (wb_adr_i),
	.wb_rdat_i (wb_dat_o),
	.wb_ack_i  (wb_ack_o)
);

// File: jag_io_top.sv
`timescale 1ns/1ns

module jag_io_top import jag_io_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	// Wishbone classic slave
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [WB_ADR_W-1:0]  wb_adr_i,
	input  logic [WB_DAT_W-1:0]  wb_dat_i,
	output logic [WB_DAT_W-1:0]  wb_dat_o,
	output logic                 wb_ack_o,
	// Controllers, active-high buttons
	input  logic [JOY_BTN_W-1:0] joystick_0_i,
	input  logic [JOY_BTN_W-1:0] joystick_1_i,
	// Unsigned analog sticks
	input  logic [ANALOG_W-1:0]  analog_0_i,
	input  logic [ANALOG_W-1:0]  analog_1_i,
	input  logic [ANALOG_W-1:0]  analog_2_i,
	input  logic [ANALOG_W-1:0]  analog_3_i,
	input  logic                 ntsc_i     // Board jumper
);

	logic                joy_wr;
	logic                adc_wr;
	ebus_wr_byte_u       wr_byte;   // Shared write byte
	logic [WB_DAT_W-1:0] joy_word;
	logic [7:0]          b_bus;
	logic [ANALOG_W-1:0] adc_data;

	joypad_scanner u_joy (
		.sys_clk      (sys_clk),
		.xresetl      (xresetl),
		.joy_wr_i     (joy_wr),
		.wr_byte_i    (wr_byte),
		.joystick_0_i (joystick_0_i),
		.joystick_1_i (joystick_1_i),
		.ntsc_i       (ntsc_i),
		.joy_word_o   (joy_word),
		.b_bus_o      (b_bus)
	);

	analog_adc u_adc (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.adc_wr_i   (adc_wr),
		.wr_byte_i  (wr_byte),
		.analog_0_i (analog_0_i),
		.analog_1_i (analog_1_i),
		.analog_2_i (analog_2_i),
		.analog_3_i (analog_3_i),
		.adc_data_o (adc_data)
	);

	ebus_mux u_ebus (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.joy_wr_o   (joy_wr),
		.adc_wr_o   (adc_wr),
		.wr_byte_o  (wr_byte),
		.joy_word_i (joy_word),
		.b_bus_i    (b_bus),
		.adc_data_i (adc_data)
	);

endmodule

// File: ebus_mux.sv
`timescale 1ns/1ns

module ebus_mux import jag_io_pkg::*; (
	input  logic                sys_clk,
	input  logic                xresetl,
	// Wishbone classic slave
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [WB_DAT_W-1:0] wb_dat_i,
	output logic [WB_DAT_W-1:0] wb_dat_o,
	output logic                wb_ack_o,
	// Write side to the peripherals
	output logic                joy_wr_o,    // Column latch load
	output logic                adc_wr_o,    // ADC command
	output ebus_wr_byte_u       wr_byte_o,
	// Read sources
	input  logic [WB_DAT_W-1:0] joy_word_i,
	input  logic [7:0]          b_bus_i,
	input  logic [ANALOG_W-1:0] adc_data_i
);

	logic                req;       // New access this cycle
	logic [WB_DAT_W-1:0] rd_word;

	// Never ack twice running, a held stb is a fresh access
	assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

	// Read combiner, unused lanes stay pulled up
	always_comb begin
		case (wb_adr_i)
			REG_JOY: rd_word = joy_word_i;
			REG_BTN: rd_word = {EBUS_PULLUP[WB_DAT_W-1:8], b_bus_i};
			REG_ADC: rd_word = {EBUS_PULLUP[WB_DAT_W-1:ANALOG_W], adc_data_i};
			default: rd_word = EBUS_PULLUP;  // Nothing drives address 3
		endcase
	end

	// Handshake and write strobes
	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			wb_ack_o <= 1'b0;
			joy_wr_o <= 1'b0;
			adc_wr_o <= 1'b0;
		end else begin
			wb_ack_o <= req;                                         // Fixed one-cycle latency
			joy_wr_o <= req & wb_we_i & (wb_adr_i == REG_JOY);
			adc_wr_o <= req & wb_we_i & (wb_adr_i == REG_ADC);
			// BTN and address 3 writes just get acked
		end
	end

	// Payload captured with the ack
	always_ff @(posedge sys_clk) begin
		if (req) begin
			wb_dat_o  <= rd_word;
			wr_byte_o <= wb_dat_i[7:0];  // Only the low byte matters
		end
	end

endmodule

// File: analog_adc.sv
`timescale 1ns/1ns

module analog_adc import jag_io_pkg::*; (
	input  logic                sys_clk,
	input  logic                xresetl,
	input  logic                adc_wr_i,    // Command strobe
	input  ebus_wr_byte_u       wr_byte_i,   // Mode and channel
	input  logic [ANALOG_W-1:0] analog_0_i,
	input  logic [ANALOG_W-1:0] analog_1_i,
	input  logic [ANALOG_W-1:0] analog_2_i,
	input  logic [ANALOG_W-1:0] analog_3_i,
	output logic [ANALOG_W-1:0] adc_data_o
);

	logic [ANALOG_W-1:0] ain [4];  // Inputs indexed by channel
	logic [ANALOG_W-1:0] adc_next;
	logic [1:0]          chan;

	// Difference clamped at zero, no wrap
	function automatic logic [ANALOG_W-1:0] sat_sub(input logic [ANALOG_W-1:0] a,
		input logic [ANALOG_W-1:0] b);
		return (a < b) ? '0 : a - b;
	endfunction

	assign ain[0] = analog_0_i;
	assign ain[1] = analog_1_i;
	assign ain[2] = analog_2_i;
	assign ain[3] = analog_3_i;
	assign chan = wr_byte_i.adc.adc_chan;

	always_comb begin
		case (wr_byte_i.adc.adc_mode)
			ADC_MODE_DIRECT: adc_next = ain[chan];
			ADC_MODE_REF3:   adc_next = (chan == 2'd3) ? adc_data_o   // Nothing to compare, hold
				: sat_sub(ain[chan], ain[3]);
			default:         adc_next = sat_sub(ain[chan], ain[chan ^ 2'b01]);  // Pair 0/1 or 2/3
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			adc_data_o <= '0;
		end else if (adc_wr_i) begin
			adc_data_o <= adc_next;  // Conversion is instant here
		end
	end

endmodule

// File: joypad_scanner.sv
`timescale 1ns/1ns

module joypad_scanner import jag_io_pkg::*; (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	input  logic                 joy_wr_i,      // Latch load strobe
	input  ebus_wr_byte_u        wr_byte_i,     // Written column byte
	input  logic [JOY_BTN_W-1:0] joystick_0_i,  // Port 1 buttons
	input  logic [JOY_BTN_W-1:0] joystick_1_i,  // Port 2 buttons
	input  logic                 ntsc_i,        // 0 = PAL, 1 = NTSC
	output logic [WB_DAT_W-1:0]  joy_word_o,
	output logic [7:0]           b_bus_o
);

	ebus_wr_byte_u col_latch;  // 74374 column latch
	logic [3:0]    p2_col_n;
	logic [5:0]    p1_row_n;
	logic [5:0]    p2_row_n;

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			col_latch <= '1;          // No column selected
		end else if (joy_wr_i) begin
			col_latch <= wr_byte_i;
		end
	end

	// Port 2 wired backwards, latch bit 7 is its column 0
	assign p2_col_n = {col_latch.joy.port2_col_n_rev[0], col_latch.joy.port2_col_n_rev[1],
		col_latch.joy.port2_col_n_rev[2], col_latch.joy.port2_col_n_rev[3]};

	keypad_matrix pad1 (
		.col_n_i   (col_latch.joy.port1_col_n),
		.buttons_i (joystick_0_i),
		.row_n_o   (p1_row_n)
	);

	keypad_matrix pad2 (
		.col_n_i   (p2_col_n),
		.buttons_i (joystick_1_i),
		.row_n_o   (p2_row_n)
	);

	// Bit 0 was EEPROM data out, idles high
	assign joy_word_o = {p2_row_n[5:2], p1_row_n[5:2], col_latch[7:1], 1'b1};

	// Rows 0-1 of both pads plus board jumpers
	assign b_bus_o = {
		1'b0,           // Unused, shorted
		1'b1,           // Unused, open
		1'b1,           // 256-column DRAM
		ntsc_i,         // Video standard jumper
		p2_row_n[1:0],  // B3, B2
		p1_row_n[1:0]   // B1, B0
	};

endmodule

// File: keypad_matrix.sv
`timescale 1ns/1ns

module keypad_matrix import jag_io_pkg::*; (
	input  logic [3:0]           col_n_i,    // Column select, active low
	input  logic [JOY_BTN_W-1:0] buttons_i,  // Active-high presses
	output logic [5:0]           row_n_o     // Row returns, active low
);

	// Presses per column, bit = row position
	logic [5:0] col0_press;
	logic [5:0] col1_press;
	logic [5:0] col2_press;
	logic [5:0] col3_press;

	// Column 0 carries the d-pad, A and pause
	assign col0_press = {
		buttons_i[0],   // Right
		buttons_i[1],   // Left
		buttons_i[2],   // Down
		buttons_i[3],   // Up
		buttons_i[4],   // A
		buttons_i[8]    // Pause
	};

	// Columns 1-3 are the keypad, row 0 empty
	assign col1_press = {
		buttons_i[9],   // 1
		buttons_i[12],  // 4
		buttons_i[15],  // 7
		buttons_i[19],  // Star
		buttons_i[5],   // B
		1'b0
	};

	assign col2_press = {
		buttons_i[10],  // 2
		buttons_i[13],  // 5
		buttons_i[16],  // 8
		buttons_i[18],  // 0
		buttons_i[6],   // C
		1'b0
	};

	assign col3_press = {
		buttons_i[11],  // 3
		buttons_i[14],  // 6
		buttons_i[17],  // 9
		buttons_i[20],  // Hash
		buttons_i[7],   // Option
		1'b0
	};

	// A row pulls low if any selected column shorts it
	assign row_n_o = ~((col0_press & {6{~col_n_i[0]}}) |
		(col1_press & {6{~col_n_i[1]}}) |
		(col2_press & {6{~col_n_i[2]}}) |
		(col3_press & {6{~col_n_i[3]}}));

endmodule

// File: jag_io_pkg.sv
package jag_io_pkg;

	// Wishbone side
	parameter int WB_ADR_W = 2;    // Word address, four registers
	parameter int WB_DAT_W = 16;   // External data bus low half

	// Controller and analog widths
	parameter int JOY_BTN_W = 21;  // Right..hash, one bit per button
	parameter int ANALOG_W = 8;    // Unsigned 0..255 inputs and ADC result

	// Register map, word addresses
	parameter logic [WB_ADR_W-1:0] REG_JOY = 2'd0;  // Column latch / joystick word
	parameter logic [WB_ADR_W-1:0] REG_BTN = 2'd1;  // b bus, rows 0-1 and jumpers
	parameter logic [WB_ADR_W-1:0] REG_ADC = 2'd2;  // ADC command / result
	// Address 3 left unmapped, reads pulled up

	// ADC command modes
	// 00 and 10 both select the pairwise difference
	parameter logic [1:0] ADC_MODE_DIRECT = 2'b01;  // Raw channel
	parameter logic [1:0] ADC_MODE_REF3 = 2'b11;    // Channel minus analog 3

	// Undriven external bus lines float high
	parameter logic [WB_DAT_W-1:0] EBUS_PULLUP = '1;

	// Low byte of a host write
	// Same byte seen by the joystick latch and by the ADC command decode
	typedef union packed {
		struct packed {
			logic [3:0] port2_col_n_rev;  // Port 2 columns, bit 7 = column 0
			logic [3:0] port1_col_n;      // Port 1 columns, active low
		} joy;
		struct packed {
			logic [3:0] unused;           // Ignored by the ADC
			logic [1:0] adc_mode;         // Difference / direct / ref 3
			logic [1:0] adc_chan;         // Channel 0..3
		} adc;
	} ebus_wr_byte_u;

endpackage
